//--- Bender.yml
package:
  name: hdd_card

sources:
  - hw/hdd_pkg.sv
  - hw/hdd_bus_decode.sv
  - hw/hdd_cmd_exec.sv
  - hw/hdd_sector_buf.sv
  - hw/hdd_read_result.sv
  - hw/hdd_slot_rom.sv
  - hw/hdd_card.sv
  - target: test
    files:
      - verif/hdd_card_tb.sv

//--- build.f
hw/hdd_pkg.sv
hw/hdd_bus_decode.sv
hw/hdd_cmd_exec.sv
hw/hdd_sector_buf.sv
hw/hdd_read_result.sv
hw/hdd_slot_rom.sv
hw/hdd_card.sv
verif/hdd_card_tb.sv

//--- hw/hdd_bus_decode.sv
/*
  Bus decoder for the device-select window.
  Exactly one request per device_select assertion; select must drop
  before the next access. Offsets 9 to F give no request.
*/
`timescale 1ns/1ps
`default_nettype none

module hdd_bus_decode (
    input  wire logic                 CLK_14M,
    input  wire logic                 RESET,
    input  wire logic                 phi0,
    input  wire logic                 device_select,
    input  wire logic                 rd,
    input  wire logic [3:0]           a_low,
    input  wire logic [7:0]           d_in,
    output hdd_pkg::hdd_bus_req_t     req
);

    logic             taken;      // Access already taken for this select
    logic             sample;
    logic             valid_q;
    logic             rd_q;
    hdd_pkg::hdd_reg_e offset_q;
    logic [7:0]       wdata_q;

    assign sample = device_select && phi0 && !taken;

    // Control ---------------
    always_ff @(posedge CLK_14M)
    begin
        if (RESET)
        begin
            taken   <= 1'b0;
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= sample && (a_low <= hdd_pkg::NEXT_BYTE);
            if (!device_select)
                taken <= 1'b0;      // Re-armed once select drops
            else if (sample)
                taken <= 1'b1;
        end
    end

    // Access payload, captured at the sampling edge
    always_ff @(posedge CLK_14M)
    begin
        if (sample)
        begin
            rd_q     <= rd;
            offset_q <= hdd_pkg::hdd_reg_e'(a_low);
            wdata_q  <= d_in;
        end
    end

    assign req.valid  = valid_q;
    assign req.rd     = rd_q;
    assign req.offset = offset_q;
    assign req.wdata  = wdata_q;

    // Executor and result stage rely on single-cycle requests
    a_req_single : assert property (
        @(posedge CLK_14M) disable iff (RESET) req.valid |=> !req.valid
    );

endmodule

`default_nettype wire

//--- hw/hdd_card.sv
/*
  ProDOS hard-disk card top level.
  6502 side: nine registers in device-select, slot ROM in io-select.
  Storage side: block number, read/write strobes and a buffer port.
  No completion handshake; a READ stays busy until 512 bytes are streamed.
*/
`timescale 1ns/1ps
`default_nettype none

module hdd_card (
    input  wire logic        CLK_14M,
    input  wire logic        RESET,
    // 6502 bus ------------
    input  wire logic        phi0,
    input  wire logic        device_select,
    input  wire logic        io_select,
    input  wire logic [15:0] a,
    input  wire logic        rd,
    input  wire logic [7:0]  d_in,
    output logic      [7:0]  d_out,
    // Storage side --------
    output logic      [15:0] sector,
    output logic             hdd_read,
    output logic             hdd_write,
    input  wire logic        hdd_mounted,
    input  wire logic        hdd_protect,
    input  wire logic [8:0]  ram_addr,
    input  wire logic [7:0]  ram_di,
    input  wire logic        ram_we,
    output logic      [7:0]  ram_do
);

    hdd_pkg::hdd_bus_req_t              req;
    hdd_pkg::hdd_regs_t                 regs;
    logic [hdd_pkg::SEC_ADDR_W-1:0]     sec_addr;
    logic                               cpu_we;
    logic [7:0]                         cpu_wdata;
    logic [7:0]                         cpu_rdata;
    logic [7:0]                         rom_q;

    assign sector = {regs.block_h, regs.block_l};

    hdd_bus_decode u_decode (
        .CLK_14M(CLK_14M), .RESET(RESET), .phi0(phi0),
        .device_select(device_select), .rd(rd), .a_low(a[3:0]),
        .d_in(d_in), .req(req)
    );

    hdd_cmd_exec u_exec (
        .CLK_14M(CLK_14M), .RESET(RESET), .req(req),
        .hdd_mounted(hdd_mounted), .hdd_protect(hdd_protect),
        .regs(regs), .sec_addr(sec_addr), .cpu_we(cpu_we),
        .cpu_wdata(cpu_wdata), .hdd_read(hdd_read), .hdd_write(hdd_write)
    );

    hdd_sector_buf u_buf (
        .CLK_14M(CLK_14M), .sec_addr(sec_addr), .cpu_we(cpu_we),
        .cpu_wdata(cpu_wdata), .cpu_rdata(cpu_rdata), .ram_addr(ram_addr),
        .ram_di(ram_di), .ram_we(ram_we), .ram_do(ram_do)
    );

    hdd_slot_rom u_rom (
        .CLK_14M(CLK_14M), .addr(a[7:0]), .q(rom_q)
    );

    hdd_read_result u_result (
        .CLK_14M(CLK_14M), .RESET(RESET), .req(req), .regs(regs),
        .cpu_rdata(cpu_rdata), .device_select(device_select),
        .io_select(io_select), .rd(rd), .rom_q(rom_q), .d_out(d_out)
    );

endmodule

`default_nettype wire

//--- hw/hdd_cmd_exec.sv
/*
  Command executor. Holds the interface registers and the sector pointer.
  Side effects land on the edge that ends the request cycle.
  FORMAT and unknown opcodes leave status alone. MEM_L/MEM_H are only
  stored; there is no DMA into 6502 memory.
*/
`timescale 1ns/1ps
`default_nettype none

module hdd_cmd_exec (
    input  wire logic                              CLK_14M,
    input  wire logic                              RESET,
    input  hdd_pkg::hdd_bus_req_t                  req,
    input  wire logic                              hdd_mounted,
    input  wire logic                              hdd_protect,
    output hdd_pkg::hdd_regs_t                     regs,
    output logic [hdd_pkg::SEC_ADDR_W-1:0]         sec_addr,
    output logic                                   cpu_we,
    output logic [7:0]                             cpu_wdata,
    output logic                                   hdd_read,
    output logic                                   hdd_write
);

    hdd_pkg::hdd_cmd_e cmd;

    assign cmd = hdd_pkg::hdd_cmd_e'(regs.command);

    // NEXT_BYTE writes go straight into the buffer
    assign cpu_we    = req.valid && !req.rd && (req.offset == hdd_pkg::NEXT_BYTE);
    assign cpu_wdata = req.wdata;

    always_ff @(posedge CLK_14M)
    begin
        if (RESET)
        begin
            regs      <= '0;
            sec_addr  <= '0;
            hdd_read  <= 1'b0;
            hdd_write <= 1'b0;
        end
        else
        begin
            hdd_read  <= 1'b0;      // Strobes are single pulses
            hdd_write <= 1'b0;
            if (req.valid && req.rd)
            begin
                case (req.offset)
                    hdd_pkg::EXEC:
                    begin
                        sec_addr <= '0;
                        case (cmd)
                            hdd_pkg::CMD_STATUS:
                                regs.status <= hdd_mounted ? hdd_pkg::ST_OK
                                                           : hdd_pkg::ST_ERROR;
                            hdd_pkg::CMD_READ:
                            begin
                                if (hdd_mounted)
                                    hdd_read <= 1'b1;   // Status stays busy
                                else
                                    regs.status <= hdd_pkg::ST_NO_DEVICE;
                            end
                            hdd_pkg::CMD_WRITE:
                            begin
                                if (hdd_protect)
                                    regs.status <= hdd_pkg::ST_PROTECT;
                                else if (hdd_mounted)
                                begin
                                    hdd_write   <= 1'b1;
                                    regs.status <= hdd_pkg::ST_OK;
                                end
                                else
                                    regs.status <= hdd_pkg::ST_NO_DEVICE;
                            end
                            hdd_pkg::CMD_FORMAT: ;  // Not supported
                            default: ;
                        endcase
                    end
                    hdd_pkg::NEXT_BYTE:
                    begin
                        sec_addr <= sec_addr + 1'b1;
                        // Last byte of the sector ends the read
                        if (&sec_addr)
                            regs.status <= hdd_pkg::ST_OK;
                    end
                    default: ;      // Plain register reads
                endcase
            end
            else if (req.valid)
            begin
                case (req.offset)
                    hdd_pkg::COMMAND:
                    begin
                        regs.command <= req.wdata;
                        sec_addr     <= '0;
                        if (req.wdata == hdd_pkg::CMD_READ ||
                            req.wdata == hdd_pkg::CMD_WRITE)
                            regs.status <= hdd_pkg::ST_BUSY;
                        else
                            regs.status <= hdd_pkg::ST_OK;
                    end
                    hdd_pkg::UNIT:      regs.unit    <= req.wdata;
                    hdd_pkg::MEM_L:     regs.mem_l   <= req.wdata;
                    hdd_pkg::MEM_H:     regs.mem_h   <= req.wdata;
                    hdd_pkg::BLOCK_L:   regs.block_l <= req.wdata;
                    hdd_pkg::BLOCK_H:   regs.block_h <= req.wdata;
                    hdd_pkg::NEXT_BYTE: sec_addr     <= sec_addr + 1'b1;
                    default: ;      // EXEC and STATUS are read only
                endcase
            end
        end
    end

    // Strobe checks ---------
    a_strobe_excl : assert property (
        @(posedge CLK_14M) disable iff (RESET) !(hdd_read && hdd_write)
    );

    a_read_pulse : assert property (
        @(posedge CLK_14M) disable iff (RESET) hdd_read |=> !hdd_read
    );

    a_write_pulse : assert property (
        @(posedge CLK_14M) disable iff (RESET) hdd_write |=> !hdd_write
    );

endmodule

`default_nettype wire

//--- hw/hdd_pkg.sv
/*
  Shared definitions for the ProDOS hard-disk card.
  Register offsets follow the device-select window, C0n0 to C0n8.
  The sector buffer holds one 512-byte ProDOS block.
*/
`default_nettype none

package hdd_pkg;

    // Register offsets ----
    typedef enum logic [3:0] {
        EXEC      = 4'h0,   // Execute, returns status
        STATUS    = 4'h1,
        COMMAND   = 4'h2,
        UNIT      = 4'h3,
        MEM_L     = 4'h4,
        MEM_H     = 4'h5,
        BLOCK_L   = 4'h6,
        BLOCK_H   = 4'h7,
        NEXT_BYTE = 4'h8    // Sector buffer stream
    } hdd_reg_e;

    // ProDOS opcodes
    typedef enum logic [7:0] {
        CMD_STATUS = 8'h00,
        CMD_READ   = 8'h01,
        CMD_WRITE  = 8'h02,
        CMD_FORMAT = 8'h03
    } hdd_cmd_e;

    // Status codes --------
    localparam logic [7:0] ST_OK        = 8'h00;
    localparam logic [7:0] ST_ERROR     = 8'h01;
    localparam logic [7:0] ST_BUSY      = 8'h80;
    localparam logic [7:0] ST_NO_DEVICE = 8'h28;
    localparam logic [7:0] ST_PROTECT   = 8'h2B;

    localparam int SECTOR_BYTES = 512;
    localparam int SEC_ADDR_W   = 9;
    localparam int ROM_ADDR_W   = 8;

    // One decoded 6502 access
    typedef struct packed {
        logic       valid;
        logic       rd;
        hdd_reg_e   offset;
        logic [7:0] wdata;
    } hdd_bus_req_t;

    typedef struct packed {
        logic [7:0] status;
        logic [7:0] command;
        logic [7:0] unit;
        logic [7:0] mem_l;
        logic [7:0] mem_h;
        logic [7:0] block_l;
        logic [7:0] block_h;
    } hdd_regs_t;

endpackage

`default_nettype wire

//--- hw/hdd_read_result.sv
/*
  Result stage for the 6502 data bus.
  A register read is captured once and held until device_select drops.
  Slot ROM data follows io_select reads; FF otherwise.
*/
`timescale 1ns/1ps
`default_nettype none

module hdd_read_result (
    input  wire logic             CLK_14M,
    input  wire logic             RESET,
    input  hdd_pkg::hdd_bus_req_t req,
    input  hdd_pkg::hdd_regs_t    regs,
    input  wire logic [7:0]       cpu_rdata,
    input  wire logic             device_select,
    input  wire logic             io_select,
    input  wire logic             rd,
    input  wire logic [7:0]       rom_q,
    output logic      [7:0]       d_out
);

    logic [7:0] reg_byte;
    logic       hold;           // Captured byte still on the bus

    // Values from before the access's side effects
    always_comb
    begin
        case (req.offset)
            hdd_pkg::EXEC,
            hdd_pkg::STATUS:    reg_byte = regs.status;
            hdd_pkg::COMMAND:   reg_byte = regs.command;
            hdd_pkg::UNIT:      reg_byte = regs.unit;
            hdd_pkg::MEM_L:     reg_byte = regs.mem_l;
            hdd_pkg::MEM_H:     reg_byte = regs.mem_h;
            hdd_pkg::BLOCK_L:   reg_byte = regs.block_l;
            hdd_pkg::BLOCK_H:   reg_byte = regs.block_h;
            hdd_pkg::NEXT_BYTE: reg_byte = cpu_rdata;
            default:            reg_byte = 8'hFF;
        endcase
    end

    always_ff @(posedge CLK_14M)
    begin
        if (RESET)
        begin
            d_out <= 8'hFF;
            hold  <= 1'b0;
        end
        else if (req.valid && req.rd)
        begin
            d_out <= reg_byte;
            hold  <= 1'b1;
        end
        else if (hold && device_select)
            d_out <= d_out;
        else
        begin
            hold  <= 1'b0;
            d_out <= (io_select && rd) ? rom_q : 8'hFF;
        end
    end

endmodule

`default_nettype wire

//--- hw/hdd_rom.hex
// Slot ROM image for the io-select page, offsets 00 to FF, 16 bytes per line
A2 20 A0 00 A2 03 86 3C 8A 0A 85 3C 20 58 FF BA
BD 00 01 0A 0A 0A 0A 85 2B AA A9 01 9D F2 C0 BD
F0 C0 D0 2B A9 08 85 27 A5 2B 85 43 A9 00 85 46
85 47 85 44 A9 08 85 45 A9 01 85 42 20 5A C7 B0
0C 4C 01 08 EA EA EA EA EA EA EA EA EA EA EA EA
4C BA FA 18 90 02 38 60 A6 2B A5 42 9D F2 C0 A5
43 9D F3 C0 A5 44 9D F4 C0 A5 45 9D F5 C0 A5 46
9D F6 C0 A5 47 9D F7 C0 BD F0 C0 D0 26 A5 42 C9
01 D0 1A A0 00 BD F8 C0 91 44 C8 D0 F8 E6 45 A0
00 BD F8 C0 91 44 C8 D0 F8 C6 45 A9 00 18 60 C9
02 D0 F7 A0 00 B1 44 9D F8 C0 C8 D0 F8 E6 45 B1
44 9D F8 C0 C8 D0 F8 C6 45 BD F0 C0 F0 DD 38 60
48 44 44 20 43 41 52 44 00 11 22 33 44 55 66 77
88 99 AA BB CC DD EE FF 0F 1E 2D 3C 4B 5A 69 78
87 96 A5 B4 C3 D2 E1 F0 01 02 04 08 10 20 40 80
FE FD FB F7 EF DF BF 7F 00 00 00 00 00 00 D7 0A

//--- hw/hdd_sector_buf.sv
/*
  Dual-port 512-byte sector RAM, registered reads on both ports.
  On a same-address write collision the storage port wins.
*/
`timescale 1ns/1ps
`default_nettype none

module hdd_sector_buf (
    input  wire logic                          CLK_14M,
    input  wire logic [hdd_pkg::SEC_ADDR_W-1:0] sec_addr,
    input  wire logic                          cpu_we,
    input  wire logic [7:0]                    cpu_wdata,
    output logic      [7:0]                    cpu_rdata,
    input  wire logic [hdd_pkg::SEC_ADDR_W-1:0] ram_addr,
    input  wire logic [7:0]                    ram_di,
    input  wire logic                          ram_we,
    output logic      [7:0]                    ram_do
);

    logic [7:0] mem [hdd_pkg::SECTOR_BYTES];

    // Storage write comes last so it overrides the CPU write
    always_ff @(posedge CLK_14M)
    begin
        if (cpu_we)
            mem[sec_addr] <= cpu_wdata;
        if (ram_we)
            mem[ram_addr] <= ram_di;
    end

    // Read ports --------------
    always_ff @(posedge CLK_14M)
    begin
        cpu_rdata <= mem[sec_addr];     // CPU side, NEXT_BYTE data
        ram_do    <= mem[ram_addr];     // Storage side
    end

    // CPU stream and disk transfer must not overlap on one byte
    a_no_collision : assert property (
        @(posedge CLK_14M) !(cpu_we && ram_we && (sec_addr == ram_addr))
    );

endmodule

`default_nettype wire

//--- hw/hdd_slot_rom.sv
/*
  256-byte slot ROM, one-clock read.
  Contents come from hw/hdd_rom.hex, path relative to the project root.
*/
`timescale 1ns/1ps
`default_nettype none

module hdd_slot_rom (
    input  wire logic                          CLK_14M,
    input  wire logic [hdd_pkg::ROM_ADDR_W-1:0] addr,
    output logic      [7:0]                    q
);

    logic [7:0] rom [2**hdd_pkg::ROM_ADDR_W];

    initial
    begin
        $readmemh("hw/hdd_rom.hex", rom);   // Boot code for the io-select page
    end

    always_ff @(posedge CLK_14M)
    begin
        q <= rom[addr];
    end

endmodule

`default_nettype wire

//--- verif/hdd_card_tb.sv
/*
  Testbench for the ProDOS hard-disk card.
  Inputs change on falling edges, one access per device_select pulse.
  Reads hw/hdd_rom.hex relative to the project root as ROM reference.
*/
`timescale 1ns/1ps
`default_nettype none

module hdd_card_tb;

    // One register access with its expected bus byte
    typedef struct packed {
        logic [3:0] offset;
        logic       rd;
        logic [7:0] data;
        logic       mounted;
        logic       protect;
        logic [7:0] expected;
    } row_t;

    logic        CLK_14M;
    logic        RESET;
    logic        phi0;
    logic        device_select;
    logic        io_select;
    logic [15:0] a;
    logic        rd;
    logic [7:0]  d_in;
    logic [7:0]  d_out;
    logic [15:0] sector;
    logic        hdd_read;
    logic        hdd_write;
    logic        hdd_mounted;
    logic        hdd_protect;
    logic [8:0]  ram_addr;
    logic [7:0]  ram_di;
    logic        ram_we;
    logic [7:0]  ram_do;

    row_t        rows[$];
    logic [7:0]  sector_data [512];
    logic [7:0]  rom_ref [256];
    logic [15:0] read_sector;
    logic [15:0] write_sector;
    int          read_count = 0;
    int          write_count = 0;

    hdd_card uut (
        .CLK_14M(CLK_14M), .RESET(RESET), .phi0(phi0), .device_select(device_select),
        .io_select(io_select), .a(a), .rd(rd), .d_in(d_in), .d_out(d_out),
        .sector(sector), .hdd_read(hdd_read), .hdd_write(hdd_write),
        .hdd_mounted(hdd_mounted), .hdd_protect(hdd_protect), .ram_addr(ram_addr),
        .ram_di(ram_di), .ram_we(ram_we), .ram_do(ram_do)
    );

    always #4 CLK_14M = ~CLK_14M;

    // Disk-side model --------
    always @(posedge CLK_14M)
    begin
        if (!RESET && hdd_read)
        begin
            read_count++;
            read_sector = sector;   // Block number latched with the strobe
        end
        if (!RESET && hdd_write)
        begin
            write_count++;
            write_sector = sector;
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        assert (got === expected)
        else
            stop_on_error($sformatf("** Error: %s = %0h, expected %0h", name, got, expected));
    endtask

    task automatic add_row(input logic [3:0] offset, input logic is_rd, input logic [7:0] data,
                           input logic mounted, input logic protect, input logic [7:0] expected);
        rows.push_back({offset, is_rd, data, mounted, protect, expected});
    endtask

    // Select with phi0 for one clock, hold four, then release for two
    task automatic bus_access(input logic [3:0] offset, input logic is_rd,
                              input logic [7:0] data, output logic [7:0] q);
        @(negedge CLK_14M);
        a             = {12'hC0F, offset};    // Slot 7
        rd            = is_rd;
        d_in          = data;
        phi0          = 1'b1;
        device_select = 1'b1;
        @(negedge CLK_14M);
        phi0 = 1'b0;
        repeat (3) @(negedge CLK_14M);
        q             = d_out;
        device_select = 1'b0;
        rd            = 1'b0;
        repeat (2) @(negedge CLK_14M);
    endtask

    task automatic rom_read(input logic [7:0] addr, output logic [7:0] q);
        @(negedge CLK_14M);
        a         = {8'hC7, addr};
        io_select = 1'b1;
        rd        = 1'b1;
        repeat (2) @(negedge CLK_14M);  // ROM read plus output register
        q         = d_out;
        io_select = 1'b0;
        rd        = 1'b0;
        @(negedge CLK_14M);
    endtask

    task automatic wait_strobe(input logic is_write, input int target);
        int cycles;
        cycles = 0;
        while ((is_write ? write_count : read_count) < target && cycles < 16)
        begin
            @(negedge CLK_14M);
            cycles++;
        end
        if (is_write && write_count < target)
            stop_on_error("Timed out waiting for an hdd_write pulse");
        else if (!is_write && read_count < target)
            stop_on_error("Timed out waiting for an hdd_read pulse");
    endtask

    // Storage port fill and dump
    task automatic fill_buffer();
        for (int i = 0; i < 512; i++)
        begin
            @(negedge CLK_14M);
            ram_addr = 9'(i);
            ram_di   = sector_data[i];
            ram_we   = 1'b1;
        end
        @(negedge CLK_14M);
        ram_we = 1'b0;
    endtask

    task automatic check_dump();
        for (int i = 0; i < 512; i++)
        begin
            @(negedge CLK_14M);
            ram_addr = 9'(i);
            @(negedge CLK_14M);
            check_value($sformatf("ram_do[%0d]", i), ram_do, sector_data[i]);
        end
    endtask

    task automatic build_table();
        for (int r = 1; r < 8; r++)
            add_row(4'(r), 1'b1, 8'h00, 1'b1, 1'b0, 8'h00);    // Reset values
        add_row(4'h0, 1'b1, 8'h00, 1'b1, 1'b0, 8'h00);
        add_row(4'h3, 1'b0, 8'h5A, 1'b1, 1'b0, 8'hFF);
        add_row(4'h4, 1'b0, 8'h34, 1'b1, 1'b0, 8'hFF);
        add_row(4'h5, 1'b0, 8'h12, 1'b1, 1'b0, 8'hFF);
        add_row(4'h6, 1'b0, 8'hCD, 1'b1, 1'b0, 8'hFF);
        add_row(4'h7, 1'b0, 8'hAB, 1'b1, 1'b0, 8'hFF);
        add_row(4'h3, 1'b1, 8'h00, 1'b1, 1'b0, 8'h5A);
        add_row(4'h4, 1'b1, 8'h00, 1'b1, 1'b0, 8'h34);
        add_row(4'h5, 1'b1, 8'h00, 1'b1, 1'b0, 8'h12);
        add_row(4'h6, 1'b1, 8'h00, 1'b1, 1'b0, 8'hCD);
        add_row(4'h7, 1'b1, 8'h00, 1'b1, 1'b0, 8'hAB);
        // STATUS command, then the error paths
        add_row(4'h2, 1'b0, 8'h00, 1'b0, 1'b0, 8'hFF);
        add_row(4'h0, 1'b1, 8'h00, 1'b0, 1'b0, 8'h00);
        add_row(4'h1, 1'b1, 8'h00, 1'b0, 1'b0, 8'h01);
        add_row(4'h0, 1'b1, 8'h00, 1'b1, 1'b0, 8'h01);
        add_row(4'h1, 1'b1, 8'h00, 1'b1, 1'b0, 8'h00);
        add_row(4'h2, 1'b0, 8'h01, 1'b0, 1'b0, 8'hFF);
        add_row(4'h0, 1'b1, 8'h00, 1'b0, 1'b0, 8'h80);
        add_row(4'h1, 1'b1, 8'h00, 1'b0, 1'b0, 8'h28);
        add_row(4'h2, 1'b0, 8'h02, 1'b1, 1'b1, 8'hFF);
        add_row(4'h0, 1'b1, 8'h00, 1'b1, 1'b1, 8'h80);
        add_row(4'h1, 1'b1, 8'h00, 1'b1, 1'b1, 8'h2B);
        add_row(4'h2, 1'b0, 8'h02, 1'b0, 1'b0, 8'hFF);
        add_row(4'h0, 1'b1, 8'h00, 1'b0, 1'b0, 8'h80);
        add_row(4'h1, 1'b1, 8'h00, 1'b0, 1'b0, 8'h28);
    endtask

    initial
    begin
        logic [7:0] q;
        logic [7:0] addr;
        CLK_14M       = 1'b0;
        RESET         = 1'b1;
        phi0          = 1'b0;
        device_select = 1'b0;
        io_select     = 1'b0;
        a             = 16'h0000;
        rd            = 1'b0;
        d_in          = 8'h00;
        hdd_mounted   = 1'b0;
        hdd_protect   = 1'b0;
        ram_addr      = 9'h000;
        ram_di        = 8'h00;
        ram_we        = 1'b0;
        void'($urandom(32'h8f8b1ece));
        $readmemh("hw/hdd_rom.hex", rom_ref);
        build_table();
        repeat (3) @(negedge CLK_14M);
        RESET = 1'b0;
        check_value("d_out", d_out, 8'hFF);

        // Register table ----
        for (int n = 0; n < rows.size(); n++)
        begin
            hdd_mounted = rows[n].mounted;
            hdd_protect = rows[n].protect;
            bus_access(rows[n].offset, rows[n].rd, rows[n].data, q);
            check_value($sformatf("d_out (row %0d)", n), q, rows[n].expected);
        end
        check_value("sector", sector, 16'hABCD);
        check_value("read_count", read_count, 0);
        check_value("write_count", write_count, 0);

        // READ stays busy until all 512 bytes are streamed
        hdd_mounted = 1'b1;
        hdd_protect = 1'b0;
        bus_access(4'h6, 1'b0, 8'h21, q);
        bus_access(4'h7, 1'b0, 8'h03, q);
        bus_access(4'h2, 1'b0, 8'h01, q);
        bus_access(4'h1, 1'b1, 8'h00, q);
        check_value("d_out", q, 8'h80);
        bus_access(4'h0, 1'b1, 8'h00, q);
        check_value("d_out", q, 8'h80);
        wait_strobe(1'b0, 1);
        check_value("read_sector", read_sector, 16'h0321);
        for (int i = 0; i < 512; i++)
            sector_data[i] = 8'($urandom);
        fill_buffer();
        for (int i = 0; i < 512; i++)
        begin
            bus_access(4'h8, 1'b1, 8'h00, q);
            check_value($sformatf("d_out (byte %0d)", i), q, sector_data[i]);
        end
        bus_access(4'h1, 1'b1, 8'h00, q);
        check_value("d_out", q, 8'h00);
        check_value("read_count", read_count, 1);

        // WRITE ----------
        bus_access(4'h6, 1'b0, 8'h44, q);
        bus_access(4'h7, 1'b0, 8'h01, q);
        bus_access(4'h2, 1'b0, 8'h02, q);
        for (int i = 0; i < 512; i++)
        begin
            sector_data[i] = 8'($urandom);
            bus_access(4'h8, 1'b0, sector_data[i], q);
        end
        bus_access(4'h0, 1'b1, 8'h00, q);
        check_value("d_out", q, 8'h80);
        wait_strobe(1'b1, 1);
        check_value("write_sector", write_sector, 16'h0144);
        bus_access(4'h1, 1'b1, 8'h00, q);
        check_value("d_out", q, 8'h00);
        check_value("write_count", write_count, 1);
        check_value("read_count", read_count, 1);
        check_dump();

        // Slot ROM and idle bus
        for (int k = 0; k < 8; k++)
        begin
            addr = (k < 4) ? 8'(k * 2 + 1) : 8'($urandom);
            if (k == 7)
                addr = 8'hFF;               // Entry point offset
            rom_read(addr, q);
            check_value($sformatf("d_out (rom %0h)", addr), q, rom_ref[addr]);
        end
        @(negedge CLK_14M);
        check_value("d_out", d_out, 8'hFF);

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire
